// File: Bender.yml
package:
  name: memory_system

sources:
  - rtl/mem_bus_pkg.sv
  - rtl/cache_pkg.sv
  - rtl/icache.sv
  - rtl/dcache.sv
  - rtl/memory_arbiter.sv
  - rtl/multicycle_memory.sv
  - rtl/memory_system.sv
  - target: simulation
    files:
      - verification/tb_memory_system.sv

// File: memory_system.f
rtl/mem_bus_pkg.sv
rtl/cache_pkg.sv
rtl/icache.sv
rtl/dcache.sv
rtl/memory_arbiter.sv
rtl/multicycle_memory.sv
rtl/memory_system.sv
verification/tb_memory_system.sv

// File: rtl/cache_pkg.sv
`default_nettype none

// cache line layout and controller states, common to both caches
package cache_pkg;

   import mem_bus_pkg::*;

   // one word per line
   // the tag is the full word address so it does not depend on line count
   typedef struct packed {
      logic  vld;
      addr_t tag;
      word_t data;
   } cache_line_t;

   // miss / write-through controller
   typedef enum logic [1:0] {
      IDLE,        // lookups served from the array
      REQUEST,     // read request just raised
      WAIT_MEM,    // read outstanding, waiting for valid
      WRITE_THRU   // dcache only, write outstanding
   } cache_state_e;

endpackage

`default_nettype wire

// File: rtl/dcache.sv
`timescale 1ns/10ps
`default_nettype none

// direct-mapped data cache
// write-through, write update on hit, no allocate on write miss
module dcache
   import mem_bus_pkg::*;
   import cache_pkg::*;
#(
   parameter int CACHE_LINES = 16
) (
   input  wire logic     clk,
   input  wire logic     i_rst_n,
   input  wire logic     i_mem_en,    // read strobe
   input  wire logic     i_wrt_en,    // write strobe
   input  wire addr_t    i_addr,
   input  wire word_t    i_wdata,
   output word_t         o_data,
   output logic          o_busy,
   output mem_req_t      o_mem_req,
   input  wire mem_rsp_t i_mem_rsp
);

   localparam int IDX_W = $clog2(CACHE_LINES);

   cache_line_t      lines [CACHE_LINES];
   cache_state_e     state;
   addr_t            req_addr;
   word_t            req_wdata;
   logic             wr_done;    // write finished last edge
   logic [IDX_W-1:0] idx;
   cache_line_t      cur_line;
   logic             hit;
   logic             rd_miss;
   logic             wr_start;

   assign idx      = i_addr[IDX_W-1:0];
   assign cur_line = lines[idx];
   assign hit      = cur_line.vld && (cur_line.tag == i_addr);
   assign o_data   = cur_line.data;

   assign rd_miss  = i_mem_en && !hit;
   // strobe still up right after completion is not a new write
   assign wr_start = i_wrt_en && !wr_done;

   // writes always go to memory so they are busy even on a hit
   assign o_busy = (state != IDLE) || rd_miss || wr_start;

   assign o_mem_req = '{
      en:    (state != IDLE),
      wr:    (state == WRITE_THRU),
      addr:  req_addr,
      wdata: req_wdata
   };

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state   <= IDLE;
         wr_done <= 1'b0;
      end else begin
         wr_done <= (state == WRITE_THRU) && i_mem_rsp.vld;
         case (state)
            IDLE: begin
               if (wr_start) begin
                  state <= WRITE_THRU;
               end else if (rd_miss) begin
                  state <= REQUEST;
               end
            end
            REQUEST: begin
               state <= WAIT_MEM;
            end
            WAIT_MEM, WRITE_THRU: begin
               if (i_mem_rsp.vld) begin
                  state <= IDLE;
               end
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   // address and data captured when an access starts
   always_ff @(posedge clk) begin
      if (state == IDLE && (wr_start || rd_miss)) begin
         req_addr  <= i_addr;
         req_wdata <= i_wdata;
      end
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < CACHE_LINES; i++) begin
            lines[i] <= '0;
         end
      end else if (state == IDLE && wr_start && hit) begin
         lines[idx].data <= i_wdata;      // update on hit, miss leaves array alone
      end else if (state == WAIT_MEM && i_mem_rsp.vld) begin
         lines[req_addr[IDX_W-1:0]] <= '{vld: 1'b1, tag: req_addr, data: i_mem_rsp.rdata};
      end
   end

   // caller issues either a read or a write, never both
   a_strobe_excl: assert property (@(posedge clk) disable iff (!i_rst_n)
      !(i_mem_en && i_wrt_en));

endmodule

`default_nettype wire

// File: rtl/icache.sv
`timescale 1ns/10ps
`default_nettype none

// direct-mapped instruction cache
// looks up the fetch address every cycle and fills one line per miss
module icache
   import mem_bus_pkg::*;
   import cache_pkg::*;
#(
   parameter int CACHE_LINES = 16
) (
   input  wire logic     clk,
   input  wire logic     i_rst_n,
   input  wire addr_t    i_addr,      // fetch address, held while busy
   output word_t         o_instr,
   output logic          o_busy,
   output mem_req_t      o_mem_req,
   input  wire mem_rsp_t i_mem_rsp
);

   localparam int IDX_W = $clog2(CACHE_LINES);

   cache_line_t      lines [CACHE_LINES];
   cache_state_e     state;
   addr_t            req_addr;            // latched miss address
   logic [IDX_W-1:0] idx;
   cache_line_t      cur_line;
   logic             hit;

   assign idx      = i_addr[IDX_W-1:0];
   assign cur_line = lines[idx];
   assign hit      = cur_line.vld && (cur_line.tag == i_addr);
   assign o_instr  = cur_line.data;

   // miss raises busy in the same cycle
   assign o_busy = (state != IDLE) || !hit;

   // read only, request is up for the whole fill
   assign o_mem_req = '{en: (state != IDLE), wr: 1'b0, addr: req_addr, wdata: '0};

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE: begin
               if (!hit) begin
                  state <= REQUEST;
               end
            end
            REQUEST: begin
               state <= WAIT_MEM;   // valid cannot come back this early
            end
            WAIT_MEM: begin
               if (i_mem_rsp.vld) begin
                  state <= IDLE;
               end
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == IDLE && !hit) begin
         req_addr <= i_addr;
      end
   end

   // line written on the valid edge, hit seen the cycle after
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < CACHE_LINES; i++) begin
            lines[i] <= '0;
         end
      end else if (state == WAIT_MEM && i_mem_rsp.vld) begin
         lines[req_addr[IDX_W-1:0]] <= '{vld: 1'b1, tag: req_addr, data: i_mem_rsp.rdata};
      end
   end

   // fetch address must not move under an outstanding read
   a_req_addr_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
      (state == WAIT_MEM) |-> $stable(i_addr));

endmodule

`default_nettype wire

// File: rtl/mem_bus_pkg.sv
`default_nettype none

// types shared by the caches, the arbiter and main memory
package mem_bus_pkg;

   // 16-bit data word
   typedef logic [15:0] word_t;

   // word address, 64K words
   typedef logic [15:0] addr_t;

   // request from a cache toward memory
   // en stays high until the matching valid pulse
   typedef struct packed {
      logic  en;      // access requested
      logic  wr;      // 1 = write, 0 = read
      addr_t addr;
      word_t wdata;   // only used on writes
   } mem_req_t;

   // response from memory
   // vld is a one-cycle pulse that closes the access
   typedef struct packed {
      logic  vld;
      word_t rdata;   // don't care on writes
   } mem_rsp_t;

endpackage

`default_nettype wire

// File: rtl/memory_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

// single memory port shared by icache and dcache
// icache wins when both ask, grant held until the valid pulse
module memory_arbiter
   import mem_bus_pkg::*;
(
   input  wire logic     clk,
   input  wire logic     i_rst_n,
   input  wire mem_req_t i_ireq,
   input  wire mem_req_t i_dreq,
   output mem_req_t      o_mem_req,
   input  wire mem_rsp_t i_mem_rsp,
   output mem_rsp_t      o_irsp,
   output mem_rsp_t      o_drsp
);

   logic own_icache;   // owner of the access in flight
   logic in_flight;
   logic sel_icache;

   // owner keeps the port until its valid pulse
   assign sel_icache = in_flight ? own_icache : i_ireq.en;
   assign o_mem_req  = sel_icache ? i_ireq : i_dreq;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         in_flight  <= 1'b0;
         own_icache <= 1'b0;
      end else if (!in_flight) begin
         if (o_mem_req.en) begin
            in_flight  <= 1'b1;          // memory accepts on this edge
            own_icache <= sel_icache;
         end
      end else if (i_mem_rsp.vld) begin
         in_flight <= 1'b0;
      end
   end

   // valid goes to the owner only
   assign o_irsp = '{vld: i_mem_rsp.vld && in_flight && own_icache,
                     rdata: i_mem_rsp.rdata};
   assign o_drsp = '{vld: i_mem_rsp.vld && in_flight && !own_icache,
                     rdata: i_mem_rsp.rdata};

   // memory only answers accesses this arbiter granted
   a_vld_in_flight: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_mem_rsp.vld |-> in_flight);

endmodule

`default_nettype wire

// File: rtl/memory_system.sv
`timescale 1ns/10ps
`default_nettype none

// instruction cache, data cache, arbiter and main memory
module memory_system
   import mem_bus_pkg::*;
#(
   parameter int CACHE_LINES = 16,
   parameter int MEM_LATENCY = 4
) (
   input  wire logic  clk,
   input  wire logic  i_rst_n,
   input  wire logic  i_d_wrt_en,
   input  wire logic  i_d_mem_en,
   input  wire word_t i_data,
   input  wire addr_t i_i_addr,
   input  wire addr_t i_d_addr,
   output logic       o_i_busy,
   output logic       o_d_busy,
   output word_t      o_instr,
   output word_t      o_data
);

   mem_req_t ireq;
   mem_req_t dreq;
   mem_req_t mem_req;    // granted request
   mem_rsp_t irsp;
   mem_rsp_t drsp;
   mem_rsp_t mem_rsp;

   icache #(.CACHE_LINES(CACHE_LINES)) u_icache (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_addr    (i_i_addr),
      .o_instr   (o_instr),
      .o_busy    (o_i_busy),
      .o_mem_req (ireq),
      .i_mem_rsp (irsp)
   );

   dcache #(.CACHE_LINES(CACHE_LINES)) u_dcache (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_mem_en  (i_d_mem_en),
      .i_wrt_en  (i_d_wrt_en),
      .i_addr    (i_d_addr),
      .i_wdata   (i_data),
      .o_data    (o_data),
      .o_busy    (o_d_busy),
      .o_mem_req (dreq),
      .i_mem_rsp (drsp)
   );

   memory_arbiter u_arbiter (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_ireq    (ireq),
      .i_dreq    (dreq),
      .o_mem_req (mem_req),
      .i_mem_rsp (mem_rsp),
      .o_irsp    (irsp),
      .o_drsp    (drsp)
   );

   multicycle_memory #(.MEM_LATENCY(MEM_LATENCY)) u_mem (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_req   (mem_req),
      .o_rsp   (mem_rsp)
   );

endmodule

`default_nettype wire

// File: rtl/multicycle_memory.sv
`timescale 1ns/10ps
`default_nettype none

// 64K-word main memory with fixed access latency
module multicycle_memory
   import mem_bus_pkg::*;
#(
   parameter int MEM_LATENCY = 4
) (
   input  wire logic     clk,
   input  wire logic     i_rst_n,
   input  wire mem_req_t i_req,
   output mem_rsp_t      o_rsp
);

   localparam int CNT_W = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;

   word_t            mem [65536];
   logic             busy;
   logic [CNT_W-1:0] cnt;        // cycles left before valid
   logic             rsp_vld;
   word_t            rsp_data;
   logic             wr_q;
   addr_t            addr_q;
   word_t            wdata_q;
   logic             accept;
   logic             done;

   // nothing taken while counting or during the valid cycle
   assign accept = i_req.en && !busy && !rsp_vld;
   assign done   = busy && (cnt == '0);

   assign o_rsp = '{vld: rsp_vld, rdata: rsp_data};

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         busy    <= 1'b0;
         cnt     <= '0;
         rsp_vld <= 1'b0;
      end else begin
         rsp_vld <= done;
         if (accept) begin
            busy <= 1'b1;
            cnt  <= CNT_W'(MEM_LATENCY - 1);
         end else if (done) begin
            busy <= 1'b0;
         end else if (busy) begin
            cnt <= cnt - 1'b1;
         end
      end
   end

   // access captured at accept, performed at the end of the count
   always_ff @(posedge clk) begin
      if (accept) begin
         wr_q    <= i_req.wr;
         addr_q  <= i_req.addr;
         wdata_q <= i_req.wdata;
      end
      if (done) begin
         if (wr_q) begin
            mem[addr_q] <= wdata_q;
         end else begin
            rsp_data <= mem[addr_q];
         end
      end
   end

   a_vld_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
      rsp_vld |=> !rsp_vld);

endmodule

`default_nettype wire

// File: verification/tb_memory_system.sv
`timescale 1ns/10ps
`default_nettype none

// directed tests for the two caches, the arbiter and main memory
module tb_memory_system
   import mem_bus_pkg::*;
();

   localparam int    CACHE_LINES    = 16;
   localparam int    MEM_LATENCY    = 4;
   localparam int    TIMEOUT_CYCLES = 20000;     // ~200 accesses x 3*(latency+3), with margin
   localparam addr_t PARK_ADDR      = 16'hff00;  // fetch address nobody writes

   logic  clk;
   logic  rst_n;
   logic  d_wrt_en;
   logic  d_mem_en;
   word_t wdata;
   addr_t fetch_addr;
   addr_t d_addr;
   logic  i_busy;
   logic  d_busy;
   word_t instr;
   word_t rdata;

   word_t model [addr_t];   // every word written through dcache
   int    cycles = 0;

   memory_system #(
      .CACHE_LINES (CACHE_LINES),
      .MEM_LATENCY (MEM_LATENCY)
   ) uut (
      .clk        (clk),
      .i_rst_n    (rst_n),
      .i_d_wrt_en (d_wrt_en),
      .i_d_mem_en (d_mem_en),
      .i_data     (wdata),
      .i_i_addr   (fetch_addr),
      .i_d_addr   (d_addr),
      .o_i_busy   (i_busy),
      .o_d_busy   (d_busy),
      .o_instr    (instr),
      .o_data     (rdata)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display(">>> FAIL");
         $fatal(1, "simulation stopped by the cycle limit");
      end
   end

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
         $display(">>> FAIL");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   // write through dcache, busy even on a hit
   task automatic write_word(input addr_t addr, input word_t value);
      @(posedge clk);
      d_wrt_en <= 1'b1;
      d_addr   <= addr;
      wdata    <= value;
      @(negedge clk);
      check_value("write_busy_rise", 1, d_busy);
      while (d_busy) begin
         @(negedge clk);
      end
      @(posedge clk);
      d_wrt_en <= 1'b0;
      model[addr] = value;
   endtask

   // missed is busy in the cycle the read is presented
   task automatic read_word(input addr_t addr, input string name, output logic missed);
      word_t expected;
      if (!model.exists(addr)) begin
         $display("read of address %h that the test never wrote", addr);
         $display(">>> FAIL");
         $fatal(1, "bad test stimulus");
      end
      expected = model[addr];
      @(posedge clk);
      d_mem_en <= 1'b1;
      d_addr   <= addr;
      @(negedge clk);
      missed = d_busy;
      while (d_busy) begin
         @(negedge clk);
      end
      check_value(name, expected, rdata);
      @(posedge clk);
      d_mem_en <= 1'b0;
   endtask

   // fetch address stays where it is afterwards
   task automatic fetch_word(input addr_t addr, input string name, output logic missed);
      @(posedge clk);
      fetch_addr <= addr;
      @(negedge clk);
      missed = i_busy;
      while (i_busy) begin
         @(negedge clk);
      end
      check_value(name, model[addr], instr);
   endtask

   task automatic test_write_read();
      logic missed;
      write_word(16'h0010, word_t'($urandom));
      read_word(16'h0010, "write_read_first", missed);
      check_value("write_read_first_miss", 1, missed);
      read_word(16'h0010, "write_read_second", missed);
      check_value("write_read_second_hit", 0, missed);
   endtask

   task automatic test_fetch();
      logic missed;
      for (int k = 0; k < 4; k++) begin
         write_word(16'h0100 + 16'(k), word_t'($urandom));
      end
      for (int k = 0; k < 4; k++) begin
         fetch_word(16'h0100 + 16'(k), "fetch_first", missed);
         check_value("fetch_first_miss", 1, missed);
         fetch_word(16'h0100 + 16'(k), "fetch_again", missed);
         check_value("fetch_again_hit", 0, missed);
      end
   endtask

   // same index, different tag
   task automatic test_conflict();
      addr_t first;
      addr_t second;
      logic  missed;
      first  = 16'h0200;
      second = 16'h0200 + 16'(CACHE_LINES);
      write_word(first, word_t'($urandom));
      write_word(second, word_t'($urandom));
      read_word(first, "conflict_first", missed);
      read_word(second, "conflict_second", missed);
      check_value("conflict_second_miss", 1, missed);
      read_word(first, "conflict_again", missed);
      check_value("conflict_again_miss", 1, missed);
   endtask

   task automatic test_write_hit();
      logic missed;
      write_word(16'h0300, word_t'($urandom));
      read_word(16'h0300, "write_hit_fill", missed);
      write_word(16'h0300, word_t'($urandom));
      read_word(16'h0300, "write_hit_update", missed);
      check_value("write_hit_update_hit", 0, missed);
   endtask

   // icache and dcache miss in the same cycle, icache is served first
   task automatic test_contention();
      int n;
      int i_fall;
      int d_fall;
      write_word(16'h0104, word_t'($urandom));
      write_word(16'h0400, word_t'($urandom));
      @(posedge clk);
      fetch_addr <= 16'h0104;
      d_mem_en   <= 1'b1;
      d_addr     <= 16'h0400;
      @(negedge clk);
      check_value("contention_i_miss", 1, i_busy);
      check_value("contention_d_miss", 1, d_busy);
      n      = 0;
      i_fall = -1;
      d_fall = -1;
      while (i_busy || d_busy) begin
         @(negedge clk);
         n++;
         if (!i_busy && i_fall < 0) begin
            i_fall = n;
         end
         if (!d_busy && d_fall < 0) begin
            d_fall = n;
         end
      end
      check_value("contention_instr", model[16'h0104], instr);
      check_value("contention_data", model[16'h0400], rdata);
      check_value("contention_order", 1, i_fall < d_fall);
      @(posedge clk);
      d_mem_en <= 1'b0;
   endtask

   // 64 addresses over 16 lines, so plenty of evictions
   task automatic test_random();
      addr_t addr;
      logic  missed;
      for (int k = 0; k < 150; k++) begin
         addr = 16'h1000 + 16'($urandom % 64);
         if (($urandom % 2 == 0) || !model.exists(addr)) begin
            write_word(addr, word_t'($urandom));
         end else begin
            read_word(addr, "random_read", missed);
         end
      end
   endtask

   initial begin
      void'($urandom(32'h9e6a8fc1));
      rst_n      = 1'b0;
      d_wrt_en   = 1'b0;
      d_mem_en   = 1'b0;
      wdata      = '0;
      fetch_addr = PARK_ADDR;
      d_addr     = '0;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      test_write_read();
      test_fetch();
      test_conflict();
      test_write_hit();
      test_contention();
      test_random();
      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire
